/* compile.f */
+incdir+hdl
hdl/timetag_pkg.sv
hdl/cmd_parser.sv
hdl/photon_tagger.sv
hdl/pulse_seq.sv
hdl/record_merger.sv
hdl/timetag_top.sv
verif/timetag_asserts.sv
verif/timetag_tb.sv

/* hdl/cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module cmd_parser (
	input  wire                     clk,
	input  wire                     rst,
	input  wire [7:0]               cmd_data,
	input  wire                     cmd_wr,
	output logic                    reg_wr,
	output timetag_pkg::reg_addr_e  reg_addr,
	output timetag_pkg::reg_value_u reg_value
);
	import timetag_pkg::*;

	// Address byte plus up to four value bytes
	localparam logic [7:0] MAX_LEN = 8'd5;

	typedef enum logic [2:0] {
		st_hunt,
		st_len,
		st_addr,
		st_value,
		st_skip
	} state_t;

	state_t      state;
	logic [7:0]  remain;
	logic [1:0]  byte_idx;
	logic [31:0] value_q;
	logic        last_byte;

	assign last_byte = (remain == 8'd1);
	assign reg_value = value_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_hunt;
			remain <= 8'd0;
			byte_idx <= 2'd0;
			reg_wr <= 1'b0;
		end else begin
			reg_wr <= 1'b0;
			if (cmd_wr) begin
				case (state)
					st_hunt: begin
						if (cmd_data == `TT_SYNC_BYTE)
							state <= st_len;
					end
					st_len: begin
						remain <= cmd_data;
						if (cmd_data == 8'd0)
							state <= st_hunt;
						else if (cmd_data > MAX_LEN)
							state <= st_skip;
						else
							state <= st_addr;
					end
					st_addr: begin
						remain <= remain - 8'd1;
						byte_idx <= 2'd0;
						if (last_byte) begin
							reg_wr <= 1'b1;
							state <= st_hunt;
						end else begin
							state <= st_value;
						end
					end
					st_value: begin
						remain <= remain - 8'd1;
						byte_idx <= byte_idx + 2'd1;
						if (last_byte) begin
							reg_wr <= 1'b1;
							state <= st_hunt;
						end
					end
					st_skip: begin
						// Oversized frame is swallowed whole
						remain <= remain - 8'd1;
						if (last_byte)
							state <= st_hunt;
					end
					default: state <= st_hunt;
				endcase
			end
		end
	end

	// Value bytes arrive least significant first
	always_ff @(posedge clk) begin
		if (cmd_wr && state == st_addr) begin
			reg_addr <= reg_addr_e'(cmd_data);
			value_q <= '0;
		end else if (cmd_wr && state == st_value) begin
			value_q[{byte_idx, 3'b000} +: 8] <= cmd_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/photon_tagger.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module photon_tagger (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [`TT_CHANNELS-1:0]       detectors,
	input  wire                          reg_wr,
	input  wire timetag_pkg::reg_addr_e  reg_addr,
	input  wire timetag_pkg::reg_value_u reg_value,
	output logic                         hit,
	output logic [`TT_CHANNELS-1:0]      hit_mask
);
	import timetag_pkg::*;

	localparam int DT_BITS = $clog2(`TT_DEADTIME + 1);

	logic [`TT_CHANNELS-1:0] det_en;
	logic [`TT_CHANNELS-1:0] sync_a;
	logic [`TT_CHANNELS-1:0] sync_b;
	logic [`TT_CHANNELS-1:0] det_prev;
	logic [`TT_CHANNELS-1:0] tag;
	logic [DT_BITS-1:0]      dead [`TT_CHANNELS];

	always_ff @(posedge clk) begin
		if (rst)
			det_en <= '0;
		else if (reg_wr && reg_addr == DET_ENABLE)
			det_en <= reg_value.mask_view.mask;
	end

	// Two flops against metastability, then the previous level for edges
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
			det_prev <= '0;
		end else begin
			sync_a <= detectors;
			sync_b <= sync_a;
			det_prev <= sync_b;
		end
	end

	always_comb begin
		for (int i = 0; i < `TT_CHANNELS; i++)
			tag[i] = det_en[i] & sync_b[i] & ~det_prev[i] & (dead[i] == '0);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit <= 1'b0;
			hit_mask <= '0;
		end else begin
			hit <= |tag;
			hit_mask <= tag;
		end
	end

	// Counter loads on the tag edge, so edges reopen TT_DEADTIME cycles later
	always_ff @(posedge clk) begin
		for (int i = 0; i < `TT_CHANNELS; i++) begin
			if (rst)
				dead[i] <= '0;
			else if (tag[i])
				dead[i] <= DT_BITS'(`TT_DEADTIME - 1);
			else if (dead[i] != '0)
				dead[i] <= dead[i] - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/pulse_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module pulse_seq (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          reg_wr,
	input  wire timetag_pkg::reg_addr_e  reg_addr,
	input  wire timetag_pkg::reg_value_u reg_value,
	output logic [`TT_CHANNELS-1:0]      laser_en,
	output logic                         toggle
);
	import timetag_pkg::*;

	localparam int IDX_BITS = $clog2(`TT_CHANNELS);

	logic [`TT_CHANNELS-1:0] run_mask;
	logic [`TT_CHANNELS-1:0] run_next;
	logic [`TT_CHANNELS-1:0] init_mask;
	logic [`TT_CHANNELS-1:0] flip;
	logic [7:0]              timing_idx;
	reg_value_u              timing [`TT_CHANNELS];
	logic [15:0]             cnt [`TT_CHANNELS];

	// Cycles left in the current level, minus one
	function automatic logic [15:0] period(reg_value_u t, logic lvl);
		return (lvl ? t.timing_view.high_count : t.timing_view.low_count) - 16'd1;
	endfunction

	assign run_next = (reg_wr && reg_addr == SEQ_RUN) ? reg_value.mask_view.mask : run_mask;
	assign timing_idx = reg_addr - SEQ_TIMING_0;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_mask <= '0;
			init_mask <= '0;
			for (int i = 0; i < `TT_CHANNELS; i++)
				timing[i] <= '0;
		end else begin
			run_mask <= run_next;
			if (reg_wr && reg_addr == SEQ_INIT)
				init_mask <= reg_value.mask_view.mask;
			if (reg_wr && timing_idx < 8'(`TT_CHANNELS))
				timing[timing_idx[IDX_BITS-1:0]] <= reg_value;
		end
	end

	// Only a channel that was running and stays running may flip
	always_comb begin
		for (int i = 0; i < `TT_CHANNELS; i++)
			flip[i] = run_next[i] & run_mask[i] & (cnt[i] == 16'd0);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			laser_en <= '0;
			toggle <= 1'b0;
			for (int i = 0; i < `TT_CHANNELS; i++)
				cnt[i] <= 16'd0;
		end else begin
			toggle <= |flip;
			for (int i = 0; i < `TT_CHANNELS; i++) begin
				if (!(run_next[i] && run_mask[i])) begin
					// Idle or just started: sit at the initial level
					laser_en[i] <= init_mask[i];
					cnt[i] <= period(timing[i], init_mask[i]);
				end else if (flip[i]) begin
					laser_en[i] <= ~laser_en[i];
					cnt[i] <= period(timing[i], ~laser_en[i]);
				end else begin
					cnt[i] <= cnt[i] - 16'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/record_merger.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module record_merger (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    hit,
	input  wire [`TT_CHANNELS-1:0] hit_mask,
	input  wire                    toggle,
	input  wire [`TT_CHANNELS-1:0] laser_en,
	output logic                   rec_valid,
	output logic [31:0]            rec_data
);
	import timetag_pkg::*;

	logic [`TT_TS_WIDTH-1:0] ts;
	logic                    park_valid;
	logic                    park_take;
	logic [31:0]             park_data;
	logic [31:0]             photon_word;
	logic [31:0]             laser_word;

	// Kind, channel mask, a zero bit, then the stamp
	function automatic logic [31:0] make_record(
		rec_kind_e                 kind,
		logic [`TT_CHANNELS-1:0]   mask,
		logic [`TT_TS_WIDTH-1:0]   stamp
	);
		return {kind, mask, 1'b0, stamp};
	endfunction

	assign photon_word = make_record(REC_PHOTON, hit_mask, ts);
	assign laser_word = make_record(REC_LASER, laser_en, ts);

	// Laser record waits when the output slot is already taken
	assign park_take = toggle & (hit | park_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			ts <= '0;
			rec_valid <= 1'b0;
			park_valid <= 1'b0;
		end else begin
			ts <= ts + 1'b1;
			rec_valid <= hit | toggle | park_valid;
			park_valid <= park_take | (park_valid & hit);
		end
	end

	// Photons first, then a parked laser record, then a fresh one
	always_ff @(posedge clk) begin
		if (park_take)
			park_data <= laser_word;
		if (hit)
			rec_data <= photon_word;
		else if (park_valid)
			rec_data <= park_data;
		else
			rec_data <= laser_word;
	end

endmodule

`default_nettype wire

/* hdl/timetag_macros.svh */
`ifndef TIMETAG_MACROS_SVH
`define TIMETAG_MACROS_SVH

// Detector inputs and laser outputs share one channel count
`define TT_CHANNELS 4

// Timestamp bits carried in every record
`define TT_TS_WIDTH 26

// Cycles after a tag during which the same channel ignores edges
`define TT_DEADTIME 8

// First byte of every host command frame
`define TT_SYNC_BYTE 8'hAA

`endif

/* hdl/timetag_pkg.sv */
`default_nettype none
`include "timetag_macros.svh"

package timetag_pkg;

	// Host register map
	typedef enum logic [7:0] {
		DET_ENABLE   = 8'h01,
		SEQ_RUN      = 8'h02,
		SEQ_INIT     = 8'h03,
		SEQ_TIMING_0 = 8'h10,
		SEQ_TIMING_1 = 8'h11,
		SEQ_TIMING_2 = 8'h12,
		SEQ_TIMING_3 = 8'h13
	} reg_addr_e;

	// Kind bit at the top of a record word
	typedef enum logic {
		REC_PHOTON = 1'b0,
		REC_LASER  = 1'b1
	} rec_kind_e;

	typedef struct packed {
		logic [31-`TT_CHANNELS:0] reserved;
		logic [`TT_CHANNELS-1:0]  mask;
	} reg_mask_t;

	// Half period lengths of one laser channel
	typedef struct packed {
		logic [15:0] high_count;
		logic [15:0] low_count;
	} reg_timing_t;

	typedef union packed {
		reg_mask_t   mask_view;
		reg_timing_t timing_view;
	} reg_value_u;

endpackage

`default_nettype wire

/* hdl/timetag_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module timetag_top (
	input  wire                     clk,
	input  wire                     rst,
	input  wire [7:0]               cmd_data,
	input  wire                     cmd_wr,
	input  wire [`TT_CHANNELS-1:0]  detectors,
	output logic [`TT_CHANNELS-1:0] laser_en,
	output logic                    rec_valid,
	output logic [31:0]             rec_data
);
	import timetag_pkg::*;

	logic                    reg_wr;
	reg_addr_e               reg_addr;
	reg_value_u              reg_value;
	logic                    hit;
	logic [`TT_CHANNELS-1:0] hit_mask;
	logic                    toggle;

	cmd_parser u_parser (
		.clk       (clk),
		.rst       (rst),
		.cmd_data  (cmd_data),
		.cmd_wr    (cmd_wr),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_value (reg_value)
	);

	// Register writes go to both blocks, each keeps its own addresses
	photon_tagger u_tagger (
		.clk       (clk),
		.rst       (rst),
		.detectors (detectors),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_value (reg_value),
		.hit       (hit),
		.hit_mask  (hit_mask)
	);

	pulse_seq u_seq (
		.clk       (clk),
		.rst       (rst),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_value (reg_value),
		.laser_en  (laser_en),
		.toggle    (toggle)
	);

	record_merger u_merger (
		.clk       (clk),
		.rst       (rst),
		.hit       (hit),
		.hit_mask  (hit_mask),
		.toggle    (toggle),
		.laser_en  (laser_en),
		.rec_valid (rec_valid),
		.rec_data  (rec_data)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module timetag_tb -f compile.f -o timetag_sim
./obj_dir/timetag_sim

/* verif/timetag_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module timetag_asserts (
	input wire        clk,
	input wire        rst,
	input wire        hit,
	input wire        toggle,
	input wire        park_valid,
	input wire        reg_wr,
	input wire [7:0]  reg_addr,
	input wire [31:0] reg_value
);

	// A collision can only park its laser record while the slot is free
	a_collision_parks: assert property (@(posedge clk) disable iff (rst)
		hit && toggle |-> !park_valid)
		else $error("collision while a laser record was still parked");

	// The parked entry leaves on the cycle it is held
	a_park_drains: assert property (@(posedge clk) disable iff (rst)
		park_valid |-> !hit)
		else $error("parked record could not leave on the next cycle");

	a_wr_single: assert property (@(posedge clk) disable iff (rst)
		reg_wr |=> !reg_wr)
		else $error("reg_wr lasted more than one cycle");

	a_min_count: assert property (@(posedge clk) disable iff (rst)
		reg_wr && reg_addr >= 8'h10 && reg_addr <= 8'h13
		|-> reg_value[31:16] >= 16'd2 && reg_value[15:0] >= 16'd2)
		else $error("timing write with a count below 2");

endmodule

bind record_merger timetag_asserts u_merger_chk (
	.clk        (clk),
	.rst        (rst),
	.hit        (hit),
	.toggle     (toggle),
	.park_valid (park_valid),
	.reg_wr     (1'b0),
	.reg_addr   (8'h00),
	.reg_value  (32'h0)
);

bind cmd_parser timetag_asserts u_parser_chk (
	.clk        (clk),
	.rst        (rst),
	.hit        (1'b0),
	.toggle     (1'b0),
	.park_valid (1'b0),
	.reg_wr     (reg_wr),
	.reg_addr   (reg_addr),
	.reg_value  (reg_value)
);

`default_nettype wire

/* verif/timetag_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "timetag_macros.svh"

module timetag_tb;
	import timetag_pkg::*;

	localparam int DRAIN_LIMIT = 200;

	// One command frame or one pulse burst, plus what it must produce
	typedef struct {
		logic [7:0]  bytes [24];
		int          nbytes;
		int          wr_pos;
		logic [7:0]  wr_a;
		logic [31:0] wr_v;
		logic [15:0] pmask;
		logic [31:0] poff;
		int          sync_ch;
		int          nphot;
		int          min_laser;
		int          wait_cyc;
	} row_t;

	logic                    clk;
	logic                    rst;
	logic [7:0]              cmd_data;
	logic                    cmd_wr;
	logic [`TT_CHANNELS-1:0] detectors;
	wire  [`TT_CHANNELS-1:0] laser_en;
	wire                     rec_valid;
	wire  [31:0]             rec_data;

	row_t        rows [16];
	int          nrows;
	int          cyc;
	logic [3:0]  m_en;
	logic [3:0]  m_run;
	logic [3:0]  m_init;
	logic [3:0]  m_lvl;
	logic [3:0]  m_prev;
	int          m_hi [4];
	int          m_lo [4];
	int          m_left [4];
	int          m_last [4];
	logic [3:0]  phot_due [int];
	logic [3:0]  las_due [int];
	logic [31:0] exp_q [$];
	logic        wr_arm;
	logic        wr_pend;
	int          wr_cyc;
	logic [7:0]  arm_a;
	logic [7:0]  pend_a;
	logic [31:0] arm_v;
	logic [31:0] pend_v;
	int          seen_phot;
	int          seen_laser;

	timetag_top DUT (
		.clk       (clk),
		.rst       (rst),
		.cmd_data  (cmd_data),
		.cmd_wr    (cmd_wr),
		.detectors (detectors),
		.laser_en  (laser_en),
		.rec_valid (rec_valid),
		.rec_data  (rec_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	function automatic int level_count(int i, logic lvl);
		return lvl ? m_hi[i] : m_lo[i];
	endfunction

	// Kind, channel mask, a zero bit, then the stamp
	function automatic logic [31:0] record_word(rec_kind_e kind, logic [3:0] mask, int stamp);
		return {kind, mask, 1'b0, stamp[`TT_TS_WIDTH-1:0]};
	endfunction

	task automatic frame_row(input logic [7:0] addr, input logic [31:0] value, input int nval,
			input int min_laser, input int wait_cyc);
		rows[nrows].bytes[0] = `TT_SYNC_BYTE;
		rows[nrows].bytes[1] = 8'(nval + 1);
		rows[nrows].bytes[2] = addr;
		for (int k = 0; k < nval; k++)
			rows[nrows].bytes[3 + k] = value[8*k +: 8];
		rows[nrows].nbytes = nval + 3;
		rows[nrows].wr_pos = nval + 2;
		rows[nrows].wr_a = addr;
		rows[nrows].wr_v = value;
		rows[nrows].pmask = 16'h0;
		rows[nrows].poff = 32'h0;
		rows[nrows].sync_ch = -1;
		rows[nrows].nphot = 0;
		rows[nrows].min_laser = min_laser;
		rows[nrows].wait_cyc = wait_cyc;
		nrows++;
	endtask

	// Masks and offsets are packed with pulse 0 in the top field
	task automatic pulse_row(input logic [15:0] pmask, input logic [31:0] poff, input int sync_ch,
			input int nphot, input int min_laser, input int wait_cyc);
		rows[nrows].nbytes = 0;
		rows[nrows].wr_pos = -1;
		rows[nrows].pmask = pmask;
		rows[nrows].poff = poff;
		rows[nrows].sync_ch = sync_ch;
		rows[nrows].nphot = nphot;
		rows[nrows].min_laser = min_laser;
		rows[nrows].wait_cyc = wait_cyc;
		nrows++;
	endtask

	task automatic fill_table();
		logic [8*17-1:0] junk;
		// Stray byte, valid enable write, oversized frame, junk, empty frame
		// The oversized frame carries an enable write for every channel
		junk = {8'h55, 8'hAA, 8'h02, 8'h01, 8'h03, 8'hAA, 8'h07, 8'h01, 8'h0F,
			8'h0F, 8'h0F, 8'h0F, 8'h0F, 8'h0F, 8'h17, 8'hAA, 8'h00};
		nrows = 0;
		frame_row(8'h00, 32'h0, 0, 0, 10);
		for (int k = 0; k < 17; k++)
			rows[0].bytes[k] = junk[8*(16-k) +: 8];
		rows[0].nbytes = 17;
		rows[0].wr_pos = 4;
		rows[0].wr_a = DET_ENABLE;
		rows[0].wr_v = 32'h3;
		pulse_row(16'h1248, {8'd0, 8'd12, 8'd24, 8'd36}, -1, 2, 0, 10);
		pulse_row(16'h1113, {8'd0, 8'd4, 8'd8, 8'd30}, -1, 3, 0, 10);
		frame_row(SEQ_TIMING_0, 32'h0006_0004, 4, 0, 4);
		frame_row(SEQ_TIMING_1, 32'h0004_0002, 4, 0, 4);
		frame_row(SEQ_INIT, 32'h2, 1, 0, 4);
		frame_row(SEQ_RUN, 32'h3, 1, 10, 60);
		pulse_row(16'h1000, 32'h0, 0, 1, 1, 20);
		frame_row(SEQ_RUN, 32'h2, 1, 3, 30);
		frame_row(SEQ_RUN, 32'h0, 1, 0, 10);
	endtask

	task automatic wait_drain();
		int guard;
		for (guard = 0; exp_q.size() != 0 || phot_due.num() != 0; guard++) begin
			if (guard == DRAIN_LIMIT)
				abort_run($sformatf("Timeout: expected record %h never came out of the DUT",
					exp_q.size() != 0 ? exp_q[0] : 32'h0));
			else
				tick();
		end
	endtask

	// Reference model and record checker, one step per clock
	always @(posedge clk) begin
		int         c;
		logic [3:0] new_run;
		logic [3:0] rise;
		logic       tog;
		logic       wr_now;
		if (rst) begin
			cyc = 0;
			m_en = '0;
			m_run = '0;
			m_init = '0;
			m_lvl = '0;
			m_prev = '0;
			wr_pend = 1'b0;
			exp_q.delete();
			phot_due.delete();
			las_due.delete();
			for (int i = 0; i < `TT_CHANNELS; i++) begin
				m_hi[i] = 0;
				m_lo[i] = 0;
				m_left[i] = 0;
				m_last[i] = -100;
			end
		end else begin
			c = cyc;
			if (rec_valid) begin
				if (exp_q.size() == 0)
					abort_run($sformatf("Record %h came out when none was expected", rec_data));
				else begin
					check("record", rec_data, exp_q.pop_front());
					if (rec_data[31])
						seen_laser++;
					else
						seen_phot++;
				end
			end
			// Photon first when both carry the same stamp
			if (phot_due.exists(c)) begin
				exp_q.push_back(record_word(REC_PHOTON, phot_due[c], c));
				phot_due.delete(c);
			end
			if (las_due.exists(c)) begin
				exp_q.push_back(record_word(REC_LASER, las_due[c], c));
				las_due.delete(c);
			end
			wr_now = wr_pend && wr_cyc == c;
			new_run = (wr_now && pend_a == SEQ_RUN) ? pend_v[3:0] : m_run;
			tog = 1'b0;
			for (int i = 0; i < `TT_CHANNELS; i++) begin
				if (m_run[i] && new_run[i]) begin
					if (m_left[i] == 1) begin
						m_lvl[i] = ~m_lvl[i];
						m_left[i] = level_count(i, m_lvl[i]);
						tog = 1'b1;
					end else
						m_left[i]--;
				end else begin
					m_lvl[i] = m_init[i];
					m_left[i] = level_count(i, m_init[i]);
				end
			end
			if (tog)
				las_due[c + 1] = m_lvl;
			if (wr_now) begin
				wr_pend = 1'b0;
				m_run = new_run;
				if (pend_a == DET_ENABLE)
					m_en = pend_v[3:0];
				if (pend_a == SEQ_INIT)
					m_init = pend_v[3:0];
				if (pend_a >= SEQ_TIMING_0 && pend_a <= SEQ_TIMING_3) begin
					m_hi[pend_a[1:0]] = int'(pend_v[31:16]);
					m_lo[pend_a[1:0]] = int'(pend_v[15:0]);
				end
			end
			if (cmd_wr && wr_arm) begin
				wr_pend = 1'b1;
				wr_cyc = c + 1;
				pend_a = arm_a;
				pend_v = arm_v;
			end
			rise = detectors & ~m_prev;
			m_prev = detectors;
			for (int i = 0; i < `TT_CHANNELS; i++) begin
				if (rise[i] && m_en[i] && c + 3 - m_last[i] >= `TT_DEADTIME) begin
					phot_due[c + 3] = (phot_due.exists(c + 3) ? phot_due[c + 3] : 4'h0) | 4'(1 << i);
					m_last[i] = c + 3;
				end
			end
			cyc = c + 1;
		end
	end

	initial begin
		int   unused_seed;
		int   elapsed;
		int   guard;
		row_t r;
		unused_seed = $urandom(32'he073);
		rst = 1'b1;
		cmd_data = 8'h00;
		cmd_wr = 1'b0;
		detectors = '0;
		wr_arm = 1'b0;
		arm_a = 8'h00;
		arm_v = 32'h0;
		seen_phot = 0;
		seen_laser = 0;
		fill_table();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < nrows; n++) begin
			r = rows[n];
			seen_phot = 0;
			seen_laser = 0;
			for (int k = 0; k < r.nbytes; k++) begin
				wr_arm = (k == r.wr_pos);
				arm_a = r.wr_a;
				arm_v = r.wr_v;
				cmd_data = r.bytes[k];
				cmd_wr = 1'b1;
				tick();
			end
			cmd_wr = 1'b0;
			wr_arm = 1'b0;
			repeat (4) tick();
			// Line the pulse up so its hit lands on the next toggle
			if (r.sync_ch >= 0) begin
				for (guard = 0; !(m_run[r.sync_ch] && m_left[r.sync_ch] == 3); guard++) begin
					if (guard == 100)
						abort_run("Sequencer never reached the collision point");
					else
						tick();
				end
			end else
				repeat ($urandom_range(15, 0)) tick();
			elapsed = 0;
			for (int p = 0; p < 4; p++) begin
				if (r.pmask[15-4*p -: 4] != 4'h0) begin
					repeat (int'(r.poff[31-8*p -: 8]) - elapsed) tick();
					detectors = r.pmask[15-4*p -: 4];
					tick();
					detectors = '0;
					elapsed = int'(r.poff[31-8*p -: 8]) + 1;
				end
			end
			repeat (r.wait_cyc) tick();
			wait_drain();
			check($sformatf("photon records in row %0d", n), seen_phot, r.nphot);
			check($sformatf("enough laser records in row %0d", n),
				32'(seen_laser >= r.min_laser), 1);
			check($sformatf("laser_en after row %0d", n), 32'(laser_en), 32'(m_lvl));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
